//--- rtl/dcache_pkg.sv
// Shared definitions for the two-stage direct-mapped data cache.
// Holds the address and line geometry, the vector types that carry a
// meaning across the stages, and the load/store function codes.
// Modules import it inside their bodies and use scoped names in their ports.

package dcache_pkg;

    // Word and address width of the load/store unit
    localparam int DC_ADDR_WIDTH   = 32;
    localparam int DC_DATA_WIDTH   = 32;

    // Cache geometry: 16 sets of 16-byte lines
    localparam int DC_LINE_BYTES   = 16;
    localparam int DC_NUM_SETS     = 16;

    // Field widths derived from the geometry
    localparam int DC_OFFSET_WIDTH = $clog2(DC_LINE_BYTES);
    localparam int DC_INDEX_WIDTH  = $clog2(DC_NUM_SETS);
    localparam int DC_TAG_WIDTH    = DC_ADDR_WIDTH - DC_INDEX_WIDTH - DC_OFFSET_WIDTH;
    localparam int DC_LINE_WIDTH   = DC_LINE_BYTES * 8;

    // Address and data words
    typedef logic [DC_ADDR_WIDTH-1:0]   dc_addr_t;
    typedef logic [DC_DATA_WIDTH-1:0]   dc_data_t;

    // One full cache line
    typedef logic [DC_LINE_WIDTH-1:0]   dc_line_t;

    // Fields of a cracked address
    typedef logic [DC_TAG_WIDTH-1:0]    dc_tag_t;
    typedef logic [DC_INDEX_WIDTH-1:0]  dc_index_t;
    typedef logic [DC_OFFSET_WIDTH-1:0] dc_offset_t;

    // Per-byte write mask over a line
    typedef logic [DC_LINE_BYTES-1:0]   dc_byte_sel_t;

    // Load/store function code
    typedef logic [2:0]                 dc_lsu_func_t;

    // Loads, signed and unsigned
    localparam dc_lsu_func_t LSU_LB  = 3'b000;
    localparam dc_lsu_func_t LSU_LH  = 3'b001;
    localparam dc_lsu_func_t LSU_LW  = 3'b010;
    localparam dc_lsu_func_t LSU_LBU = 3'b011;
    localparam dc_lsu_func_t LSU_LHU = 3'b100;

    // Stores
    localparam dc_lsu_func_t LSU_SB  = 3'b101;
    localparam dc_lsu_func_t LSU_SH  = 3'b110;
    localparam dc_lsu_func_t LSU_SW  = 3'b111;

endpackage

//--- rtl/cache_ram.sv
// Tag, state and line storage for a direct-mapped cache.
// One write port and one read port, both on the rising edge of clk.
// The read is registered every cycle and is write-first, so a read of
// the set being written returns the new tag, state and line.

`timescale 1ns/1ps

module cache_ram #(
    parameter int TAG_WIDTH   = 24,
    parameter int INDEX_WIDTH = 4,
    parameter int LINE_WIDTH  = 128
) (
    input  logic                   clk,
    input  logic                   i_rst,

    input  logic                   i_wr_en,
    input  logic [INDEX_WIDTH-1:0] i_wr_index,
    input  logic                   i_wr_valid,
    input  logic                   i_wr_dirty,
    input  logic [TAG_WIDTH-1:0]   i_wr_tag,
    input  logic [LINE_WIDTH-1:0]  i_wr_line,

    input  logic [INDEX_WIDTH-1:0] i_rd_index,
    output logic                   o_rd_valid,
    output logic                   o_rd_dirty,
    output logic [TAG_WIDTH-1:0]   o_rd_tag,
    output logic [LINE_WIDTH-1:0]  o_rd_line
);

    localparam int NUM_SETS = 1 << INDEX_WIDTH;

    logic [TAG_WIDTH-1:0]  tag_mem  [NUM_SETS];
    logic [LINE_WIDTH-1:0] line_mem [NUM_SETS];
    logic [NUM_SETS-1:0]   valid_q;
    logic [NUM_SETS-1:0]   dirty_q;
    logic                  collide;

    // A write to the set being read this cycle wins over the stored copy
    assign collide = i_wr_en && (i_wr_index == i_rd_index);

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            line_mem[i_wr_index] <= i_wr_line;
        end
    end

    // Every set starts out invalid and clean
    always_ff @(posedge clk) begin
        if (i_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_wr_en) begin
            valid_q[i_wr_index] <= i_wr_valid;
            dirty_q[i_wr_index] <= i_wr_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_rd_valid <= 1'b0;
            o_rd_dirty <= 1'b0;
        end else begin
            o_rd_valid <= collide ? i_wr_valid : valid_q[i_rd_index];
            o_rd_dirty <= collide ? i_wr_dirty : dirty_q[i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        o_rd_tag  <= collide ? i_wr_tag  : tag_mem[i_rd_index];
        o_rd_line <= collide ? i_wr_line : line_mem[i_rd_index];
    end

endmodule

//--- rtl/dcache_d0.sv
// Stage 0 of the data cache.
// Registers the request while the RAM read is in flight. Store data is
// moved to its byte position within a line and a byte mask is built from
// the function code and offset. A fill takes the fill line and marks every
// byte of the line for writing.

`timescale 1ns/1ps

module dcache_d0 (
    input  logic                    clk,
    input  logic                    i_rst,

    input  logic                    i_wr_en,
    input  dcache_pkg::dc_tag_t      i_tag,
    input  dcache_pkg::dc_index_t    i_index,
    input  dcache_pkg::dc_offset_t   i_offset,
    input  dcache_pkg::dc_lsu_func_t i_lsu_func,
    input  dcache_pkg::dc_data_t     i_data,
    input  logic                    i_fill,
    input  dcache_pkg::dc_line_t     i_fill_data,
    input  logic                    i_valid,
    input  logic                    i_dirty,

    output logic                    o_wr_en,
    output dcache_pkg::dc_tag_t      o_tag,
    output dcache_pkg::dc_index_t    o_index,
    output dcache_pkg::dc_offset_t   o_offset,
    output dcache_pkg::dc_lsu_func_t o_lsu_func,
    output dcache_pkg::dc_byte_sel_t o_byte_sel,
    output dcache_pkg::dc_line_t     o_line,
    output logic                    o_fill,
    output logic                    o_valid,
    output logic                    o_dirty
);

    import dcache_pkg::*;

    logic [3:0]   size_mask;
    dc_byte_sel_t byte_sel;
    dc_line_t     line;

    // Bytes touched by a store, before the shift to the offset
    always_comb begin
        case (i_lsu_func)
            LSU_SB:  size_mask = 4'b0001;
            LSU_SH:  size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    always_comb begin
        if (i_fill) begin
            byte_sel = '1;
            line     = i_fill_data;
        end else begin
            byte_sel = i_wr_en ? (dc_byte_sel_t'(size_mask) << i_offset) : '0;
            line     = dc_line_t'(i_data) << {i_offset, 3'b000};
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wr_en <= 1'b0;
            o_fill  <= 1'b0;
        end else begin
            o_wr_en <= i_wr_en;
            o_fill  <= i_fill;
        end
    end

    always_ff @(posedge clk) begin
        o_tag      <= i_tag;
        o_index    <= i_index;
        o_offset   <= i_offset;
        o_lsu_func <= i_lsu_func;
        o_byte_sel <= byte_sel;
        o_line     <= line;
        o_valid    <= i_valid;
        o_dirty    <= i_dirty;
    end

endmodule

//--- rtl/dcache_d1.sv
// Stage 1 of the data cache.
// Picks the current set state from the write-back bus or the RAM read,
// decides hit, extracts and extends load data, merges store bytes or takes
// the fill line, and registers the RAM write together with the outputs.
// Victim fields describe the line that a fill replaces.

`timescale 1ns/1ps

module dcache_d1 (
    input  logic                    clk,
    input  logic                    i_rst,

    input  logic                    i_wr_en,
    input  dcache_pkg::dc_tag_t      i_tag,
    input  dcache_pkg::dc_index_t    i_index,
    input  dcache_pkg::dc_offset_t   i_offset,
    input  dcache_pkg::dc_lsu_func_t i_lsu_func,
    input  dcache_pkg::dc_byte_sel_t i_byte_sel,
    input  dcache_pkg::dc_line_t     i_line,
    input  logic                    i_fill,
    input  logic                    i_valid,
    input  logic                    i_dirty,

    input  logic                    i_cache_rd_valid,
    input  logic                    i_cache_rd_dirty,
    input  dcache_pkg::dc_tag_t      i_cache_rd_tag,
    input  dcache_pkg::dc_line_t     i_cache_rd_line,

    input  logic                    i_bypass_wr_en,
    input  dcache_pkg::dc_index_t    i_bypass_wr_index,
    input  logic                    i_bypass_wr_valid,
    input  logic                    i_bypass_wr_dirty,
    input  dcache_pkg::dc_tag_t      i_bypass_wr_tag,
    input  dcache_pkg::dc_line_t     i_bypass_wr_line,

    output logic                    o_cache_wr_en,
    output dcache_pkg::dc_index_t    o_cache_wr_index,
    output logic                    o_cache_wr_valid,
    output logic                    o_cache_wr_dirty,
    output dcache_pkg::dc_tag_t      o_cache_wr_tag,
    output dcache_pkg::dc_line_t     o_cache_wr_line,

    output logic                    o_hit,
    output dcache_pkg::dc_data_t     o_data,
    output logic                    o_victim_valid,
    output logic                    o_victim_dirty,
    output dcache_pkg::dc_addr_t     o_victim_addr,
    output dcache_pkg::dc_line_t     o_victim_line
);

    import dcache_pkg::*;

    logic     use_bypass;
    logic     cur_valid;
    logic     cur_dirty;
    dc_tag_t  cur_tag;
    dc_line_t cur_line;
    logic     hit;
    dc_line_t shifted;
    dc_data_t word;
    dc_data_t load_data;
    dc_line_t merged;

    // The previous request's write is still on its way into the RAM
    assign use_bypass = i_bypass_wr_en && (i_bypass_wr_index == i_index);

    assign cur_valid = use_bypass ? i_bypass_wr_valid : i_cache_rd_valid;
    assign cur_dirty = use_bypass ? i_bypass_wr_dirty : i_cache_rd_dirty;
    assign cur_tag   = use_bypass ? i_bypass_wr_tag   : i_cache_rd_tag;
    assign cur_line  = use_bypass ? i_bypass_wr_line  : i_cache_rd_line;

    assign hit     = !i_fill && cur_valid && (cur_tag == i_tag);
    assign shifted = cur_line >> {i_offset, 3'b000};
    assign word    = shifted[DC_DATA_WIDTH-1:0];

    // Only a load that hits returns data, anything else reads as zero
    always_comb begin
        load_data = '0;
        if (hit && !i_wr_en) begin
            case (i_lsu_func)
                LSU_LB:  load_data = {{(DC_DATA_WIDTH-8){word[7]}}, word[7:0]};
                LSU_LH:  load_data = {{(DC_DATA_WIDTH-16){word[15]}}, word[15:0]};
                LSU_LBU: load_data = {{(DC_DATA_WIDTH-8){1'b0}}, word[7:0]};
                LSU_LHU: load_data = {{(DC_DATA_WIDTH-16){1'b0}}, word[15:0]};
                default: load_data = word;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < DC_LINE_BYTES; i++) begin
            merged[i*8 +: 8] = i_byte_sel[i] ? i_line[i*8 +: 8] : cur_line[i*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_cache_wr_en  <= 1'b0;
            o_hit          <= 1'b0;
            o_victim_valid <= 1'b0;
        end else begin
            o_cache_wr_en  <= i_fill || (i_wr_en && hit);
            o_hit          <= hit;
            o_victim_valid <= i_fill && cur_valid;
        end
    end

    // A store hit leaves the line valid and dirty
    always_ff @(posedge clk) begin
        o_cache_wr_index <= i_index;
        o_cache_wr_valid <= i_fill ? i_valid : 1'b1;
        o_cache_wr_dirty <= i_fill ? i_dirty : 1'b1;
        o_cache_wr_tag   <= i_tag;
        o_cache_wr_line  <= i_fill ? i_line : merged;
        o_data           <= load_data;
        o_victim_dirty   <= cur_dirty;
        o_victim_addr    <= {cur_tag, i_index, {DC_OFFSET_WIDTH{1'b0}}};
        o_victim_line    <= cur_line;
    end

endmodule

//--- rtl/dcache.sv
// Top level of the two-stage direct-mapped write-back data cache.
// A request is taken every cycle; hit, load data and victim fields appear
// one cycle later. Fills and their state come from outside, and the victim
// outputs tell the memory side what a fill has pushed out.

`timescale 1ns/1ps

module dcache (
    input  logic                    clk,
    input  logic                    i_rst,

    input  logic                    i_dc_wr_en,
    input  dcache_pkg::dc_addr_t     i_dc_addr,
    input  dcache_pkg::dc_data_t     i_dc_data,
    input  dcache_pkg::dc_lsu_func_t i_dc_lsu_func,
    input  logic                    i_dc_valid,
    input  logic                    i_dc_dirty,
    input  logic                    i_dc_fill,
    input  dcache_pkg::dc_line_t     i_dc_fill_data,

    output logic                    o_dc_hit,
    output dcache_pkg::dc_data_t     o_dc_data,
    output logic                    o_dc_victim_valid,
    output logic                    o_dc_victim_dirty,
    output dcache_pkg::dc_addr_t     o_dc_victim_addr,
    output dcache_pkg::dc_line_t     o_dc_victim_data
);

    import dcache_pkg::*;

    dc_tag_t      dc_tag;
    dc_index_t    dc_index;
    dc_offset_t   dc_offset;

    logic         d0_wr_en;
    dc_tag_t      d0_tag;
    dc_index_t    d0_index;
    dc_offset_t   d0_offset;
    dc_lsu_func_t d0_lsu_func;
    dc_byte_sel_t d0_byte_sel;
    dc_line_t     d0_line;
    logic         d0_fill;
    logic         d0_valid;
    logic         d0_dirty;

    logic         cache_rd_valid;
    logic         cache_rd_dirty;
    dc_tag_t      cache_rd_tag;
    dc_line_t     cache_rd_line;

    logic         cache_wr_en;
    dc_index_t    cache_wr_index;
    logic         cache_wr_valid;
    logic         cache_wr_dirty;
    dc_tag_t      cache_wr_tag;
    dc_line_t     cache_wr_line;

    // Split the address into tag, set index and byte offset
    assign dc_tag    = i_dc_addr[DC_ADDR_WIDTH-1 -: DC_TAG_WIDTH];
    assign dc_index  = i_dc_addr[DC_OFFSET_WIDTH +: DC_INDEX_WIDTH];
    assign dc_offset = i_dc_addr[DC_OFFSET_WIDTH-1:0];

    dcache_d0 dcache_d0_inst (
        .clk(clk), .i_rst(i_rst),
        .i_wr_en(i_dc_wr_en), .i_tag(dc_tag), .i_index(dc_index), .i_offset(dc_offset),
        .i_lsu_func(i_dc_lsu_func), .i_data(i_dc_data),
        .i_fill(i_dc_fill), .i_fill_data(i_dc_fill_data),
        .i_valid(i_dc_valid), .i_dirty(i_dc_dirty),
        .o_wr_en(d0_wr_en), .o_tag(d0_tag), .o_index(d0_index), .o_offset(d0_offset),
        .o_lsu_func(d0_lsu_func), .o_byte_sel(d0_byte_sel), .o_line(d0_line),
        .o_fill(d0_fill), .o_valid(d0_valid), .o_dirty(d0_dirty)
    );

    // The registered write bus loops back as the bypass for the next request
    dcache_d1 dcache_d1_inst (
        .clk(clk), .i_rst(i_rst),
        .i_wr_en(d0_wr_en), .i_tag(d0_tag), .i_index(d0_index), .i_offset(d0_offset),
        .i_lsu_func(d0_lsu_func), .i_byte_sel(d0_byte_sel), .i_line(d0_line),
        .i_fill(d0_fill), .i_valid(d0_valid), .i_dirty(d0_dirty),
        .i_cache_rd_valid(cache_rd_valid), .i_cache_rd_dirty(cache_rd_dirty),
        .i_cache_rd_tag(cache_rd_tag), .i_cache_rd_line(cache_rd_line),
        .i_bypass_wr_en(cache_wr_en), .i_bypass_wr_index(cache_wr_index),
        .i_bypass_wr_valid(cache_wr_valid), .i_bypass_wr_dirty(cache_wr_dirty),
        .i_bypass_wr_tag(cache_wr_tag), .i_bypass_wr_line(cache_wr_line),
        .o_cache_wr_en(cache_wr_en), .o_cache_wr_index(cache_wr_index),
        .o_cache_wr_valid(cache_wr_valid), .o_cache_wr_dirty(cache_wr_dirty),
        .o_cache_wr_tag(cache_wr_tag), .o_cache_wr_line(cache_wr_line),
        .o_hit(o_dc_hit), .o_data(o_dc_data),
        .o_victim_valid(o_dc_victim_valid), .o_victim_dirty(o_dc_victim_dirty),
        .o_victim_addr(o_dc_victim_addr), .o_victim_line(o_dc_victim_data)
    );

    cache_ram #(
        .TAG_WIDTH(DC_TAG_WIDTH),
        .INDEX_WIDTH(DC_INDEX_WIDTH),
        .LINE_WIDTH(DC_LINE_WIDTH)
    ) cache_ram_inst (
        .clk(clk), .i_rst(i_rst),
        .i_wr_en(cache_wr_en), .i_wr_index(cache_wr_index),
        .i_wr_valid(cache_wr_valid), .i_wr_dirty(cache_wr_dirty),
        .i_wr_tag(cache_wr_tag), .i_wr_line(cache_wr_line),
        .i_rd_index(dc_index),
        .o_rd_valid(cache_rd_valid), .o_rd_dirty(cache_rd_dirty),
        .o_rd_tag(cache_rd_tag), .o_rd_line(cache_rd_line)
    );

endmodule

//--- tb/dcache_props.sv
// Concurrent checks on the data cache, bound into the dcache top level.
// They cover the state of the outputs after reset, victim reporting
// and the rule that a fill never reports a hit.

`timescale 1ns/1ps

module dcache_props (
    input logic clk,
    input logic i_rst,
    input logic d0_fill,
    input logic cache_wr_en,
    input logic o_dc_hit,
    input logic o_dc_victim_valid
);

    // Synchronous reset leaves hit, victim and the RAM write quiet
    reset_clears_outputs: assert property (
        @(posedge clk) i_rst |=> (!o_dc_hit && !o_dc_victim_valid && !cache_wr_en)
    ) else $error("Hit, victim or RAM write still active after reset");

    // A victim is only reported for a fill that sat in stage 1
    victim_follows_fill: assert property (
        @(posedge clk) disable iff (i_rst) o_dc_victim_valid |-> $past(d0_fill)
    ) else $error("Victim reported without a fill in the previous cycle");

    no_hit_on_fill: assert property (
        @(posedge clk) disable iff (i_rst) d0_fill |=> !o_dc_hit
    ) else $error("Hit reported for a fill");

endmodule

bind dcache dcache_props props0 (
    .clk(clk),
    .i_rst(i_rst),
    .d0_fill(d0_fill),
    .cache_wr_en(cache_wr_en),
    .o_dc_hit(o_dc_hit),
    .o_dc_victim_valid(o_dc_victim_valid)
);

//--- tb/dcache_tb.sv
// Testbench for the two-stage direct-mapped data cache.
// Requests and expected responses come from tb/dcache_vectors.txt. They are
// streamed into the DUT back to back on falling clock edges, and each
// response is checked one full cycle after the DUT has taken the request.
// Random idle loads to an otherwise unused set are placed between tests.

`timescale 1ns/1ps

module dcache_tb;

    import dcache_pkg::*;

    localparam int    MAX_VEC  = 64;
    localparam string VEC_FILE = "tb/dcache_vectors.txt";

    logic         clk;
    logic         i_rst;
    logic         i_dc_wr_en;
    dc_addr_t     i_dc_addr;
    dc_data_t     i_dc_data;
    dc_lsu_func_t i_dc_lsu_func;
    logic         i_dc_valid;
    logic         i_dc_dirty;
    logic         i_dc_fill;
    dc_line_t     i_dc_fill_data;
    logic         o_dc_hit;
    dc_data_t     o_dc_data;
    logic         o_dc_victim_valid;
    logic         o_dc_victim_dirty;
    dc_addr_t     o_dc_victim_addr;
    dc_line_t     o_dc_victim_data;

    // One entry per vector line with the request fields first
    int       v_test   [MAX_VEC];
    string    v_op     [MAX_VEC];
    dc_addr_t v_addr   [MAX_VEC];
    dc_data_t v_data   [MAX_VEC];
    dc_line_t v_fill   [MAX_VEC];
    logic     v_valid  [MAX_VEC];
    logic     v_dirty  [MAX_VEC];
    logic     v_hit    [MAX_VEC];
    dc_data_t v_rdata  [MAX_VEC];
    logic     v_vvalid [MAX_VEC];
    logic     v_vdirty [MAX_VEC];
    dc_addr_t v_vaddr  [MAX_VEC];
    dc_line_t v_vline  [MAX_VEC];

    int num_vec       = 0;
    int cycles        = 0;
    int cycle_limit   = 0;
    int checks        = 0;
    int errors        = 0;
    int group_errors  = 0;
    int groups_passed = 0;
    int groups_failed = 0;
    int cur_group     = 0;

    // Vector index of each request still in the pipe where -1 marks an idle load
    int inflight[$];

    dcache dut0 (
        .clk(clk), .i_rst(i_rst),
        .i_dc_wr_en(i_dc_wr_en), .i_dc_addr(i_dc_addr), .i_dc_data(i_dc_data),
        .i_dc_lsu_func(i_dc_lsu_func), .i_dc_valid(i_dc_valid), .i_dc_dirty(i_dc_dirty),
        .i_dc_fill(i_dc_fill), .i_dc_fill_data(i_dc_fill_data),
        .o_dc_hit(o_dc_hit), .o_dc_data(o_dc_data),
        .o_dc_victim_valid(o_dc_victim_valid), .o_dc_victim_dirty(o_dc_victim_dirty),
        .o_dc_victim_addr(o_dc_victim_addr), .o_dc_victim_data(o_dc_victim_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the vectors did not drain in time", cycles);
        $display("Test failed");
        $finish;
    end

    task automatic read_vectors();
        int    fd;
        int    n;
        string line;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VEC_FILE);
            errors++;
        end else begin
            while (!$feof(fd) && num_vec < MAX_VEC) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %s %h %h %h %h %h %h %h %h %h %h %h",
                        v_test[num_vec], v_op[num_vec], v_addr[num_vec], v_data[num_vec],
                        v_fill[num_vec], v_valid[num_vec], v_dirty[num_vec],
                        v_hit[num_vec], v_rdata[num_vec], v_vvalid[num_vec],
                        v_vdirty[num_vec], v_vaddr[num_vec], v_vline[num_vec]);
                    if (n == 13) begin
                        num_vec++;
                    end else begin
                        $display("Vector line could not be parsed: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_request(int idx);
        i_dc_wr_en = 1'b0;
        i_dc_fill  = 1'b0;
        if (idx < 0) begin
            // Set 15 is kept free of test traffic
            i_dc_lsu_func  = LSU_LW;
            i_dc_addr      = {dc_tag_t'($urandom), 4'hF, 4'h0};
            i_dc_data      = $urandom;
            i_dc_valid     = 1'b0;
            i_dc_dirty     = 1'b0;
            i_dc_fill_data = '0;
        end else begin
            i_dc_addr      = v_addr[idx];
            i_dc_data      = v_data[idx];
            i_dc_valid     = v_valid[idx];
            i_dc_dirty     = v_dirty[idx];
            i_dc_fill_data = v_fill[idx];
            case (v_op[idx])
                "LB":    i_dc_lsu_func = LSU_LB;
                "LH":    i_dc_lsu_func = LSU_LH;
                "LW":    i_dc_lsu_func = LSU_LW;
                "LBU":   i_dc_lsu_func = LSU_LBU;
                "LHU":   i_dc_lsu_func = LSU_LHU;
                "SB": begin
                    i_dc_lsu_func = LSU_SB;
                    i_dc_wr_en    = 1'b1;
                end
                "SH": begin
                    i_dc_lsu_func = LSU_SH;
                    i_dc_wr_en    = 1'b1;
                end
                "SW": begin
                    i_dc_lsu_func = LSU_SW;
                    i_dc_wr_en    = 1'b1;
                end
                "FILL": begin
                    i_dc_lsu_func = LSU_LW;
                    i_dc_fill     = 1'b1;
                end
                default: begin
                    $display("Unknown operation %s in vector %0d", v_op[idx], idx);
                    i_dc_lsu_func = LSU_LW;
                    errors++;
                end
            endcase
        end
    endtask

    task automatic report_mismatch(int idx, string name, string got, string exp);
        $display("Fail test %0d vector %0d: %s = %s, expected %s",
            v_test[idx], idx, name, got, exp);
        errors++;
        group_errors++;
    endtask

    task automatic finish_group();
        if (cur_group > 0) begin
            if (group_errors == 0) begin
                $display("Test %0d passed", cur_group);
                groups_passed++;
            end else begin
                $display("Test %0d failed with %0d mismatches", cur_group, group_errors);
                groups_failed++;
            end
        end
        group_errors = 0;
    endtask

    task automatic check_response(int idx);
        if (v_test[idx] != cur_group) begin
            finish_group();
            cur_group = v_test[idx];
        end
        checks++;
        if (o_dc_hit !== v_hit[idx])
            report_mismatch(idx, "o_dc_hit", $sformatf("%h", o_dc_hit),
                $sformatf("%h", v_hit[idx]));
        if (o_dc_data !== v_rdata[idx])
            report_mismatch(idx, "o_dc_data", $sformatf("%h", o_dc_data),
                $sformatf("%h", v_rdata[idx]));
        if (o_dc_victim_valid !== v_vvalid[idx])
            report_mismatch(idx, "o_dc_victim_valid", $sformatf("%h", o_dc_victim_valid),
                $sformatf("%h", v_vvalid[idx]));
        // The other victim fields only mean something with a valid victim
        if (v_vvalid[idx] === 1'b1) begin
            if (o_dc_victim_dirty !== v_vdirty[idx])
                report_mismatch(idx, "o_dc_victim_dirty", $sformatf("%h", o_dc_victim_dirty),
                    $sformatf("%h", v_vdirty[idx]));
            if (o_dc_victim_addr !== v_vaddr[idx])
                report_mismatch(idx, "o_dc_victim_addr", $sformatf("%h", o_dc_victim_addr),
                    $sformatf("%h", v_vaddr[idx]));
            if (o_dc_victim_data !== v_vline[idx])
                report_mismatch(idx, "o_dc_victim_data", $sformatf("%h", o_dc_victim_data),
                    $sformatf("%h", v_vline[idx]));
        end
    endtask

    // A request driven at one falling edge is answered two falling edges later
    task automatic issue(int idx);
        int done_idx;
        @(negedge clk);
        if (inflight.size() == 2) begin
            done_idx = inflight.pop_front();
            if (done_idx >= 0)
                check_response(done_idx);
        end
        apply_request(idx);
        inflight.push_back(idx);
    endtask

    initial begin
        int gap;
        void'($urandom(32'ha3b0));
        i_rst          = 1'b1;
        i_dc_wr_en     = 1'b0;
        i_dc_addr      = '0;
        i_dc_data      = '0;
        i_dc_lsu_func  = LSU_LW;
        i_dc_valid     = 1'b0;
        i_dc_dirty     = 1'b0;
        i_dc_fill      = 1'b0;
        i_dc_fill_data = '0;
        read_vectors();
        cycle_limit = 2 * num_vec + 50;
        if (num_vec == 0) begin
            $display("No usable vectors were found in %s", VEC_FILE);
            errors++;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        i_rst = 1'b0;
        for (int i = 0; i < num_vec; i++) begin
            if (i > 0 && v_test[i] != v_test[i-1]) begin
                gap = $urandom % 4;
                repeat (gap) issue(-1);
            end
            issue(i);
        end
        repeat (2) issue(-1);
        finish_group();
        $display("Summary: %0d vectors, %0d checked, %0d errors, %0d tests passed, %0d failed",
            num_vec, checks, errors, groups_passed, groups_failed);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- tb/dcache_vectors.txt
# test op addr data fill_line valid dirty | exp_hit exp_data vic_valid vic_dirty vic_addr vic_line
# All fields are hex except test; fields that do not apply hold 0
1 LW   00000100 0 0 0 0 0 0 0 0 0 0
1 LW   00001230 0 0 0 0 0 0 0 0 0 0
1 LBU  0000ABC4 0 0 0 0 0 0 0 0 0 0
1 LH   12345678 0 0 0 0 0 0 0 0 0 0
2 FILL 1020 0 CAFEBABE12345678F0E1D2C380817F7E 1 0 0 0 0 0 0 0
2 LW   1020 0 0 0 0 1 80817F7E 0 0 0 0
2 LW   102C 0 0 0 0 1 CAFEBABE 0 0 0 0
2 LH   1022 0 0 0 0 1 FFFF8081 0 0 0 0
2 LH   1020 0 0 0 0 1 00007F7E 0 0 0 0
2 LHU  1022 0 0 0 0 1 00008081 0 0 0 0
2 LB   1022 0 0 0 0 1 FFFFFF81 0 0 0 0
2 LB   1021 0 0 0 0 1 0000007F 0 0 0 0
2 LBU  1027 0 0 0 0 1 000000F0 0 0 0 0
2 LBU  1026 0 0 0 0 1 000000E1 0 0 0 0
2 LB   1026 0 0 0 0 1 FFFFFFE1 0 0 0 0
2 LH   1024 0 0 0 0 1 FFFFD2C3 0 0 0 0
2 LHU  1028 0 0 0 0 1 00005678 0 0 0 0
3 SB   1021 000000AA 0 0 0 1 0 0 0 0 0
3 LW   1020 0 0 0 0 1 8081AA7E 0 0 0 0
3 SH   1026 00001234 0 0 0 1 0 0 0 0 0
3 LB   1021 0 0 0 0 1 FFFFFFAA 0 0 0 0
3 LHU  1026 0 0 0 0 1 00001234 0 0 0 0
3 SW   102C DEADBEEF 0 0 0 1 0 0 0 0 0
3 SW   1028 0BADF00D 0 0 0 1 0 0 0 0 0
3 LW   102C 0 0 0 0 1 DEADBEEF 0 0 0 0
3 LW   1028 0 0 0 0 1 0BADF00D 0 0 0 0
3 LH   102E 0 0 0 0 1 FFFFDEAD 0 0 0 0
3 SW   2020 11111111 0 0 0 0 0 0 0 0 0
3 LW   1020 0 0 0 0 1 8081AA7E 0 0 0 0
3 LW   2020 0 0 0 0 0 0 0 0 0 0
4 FILL 3020 0 0123456789ABCDEF0011223344556677 1 0 0 0 1 1 1020 DEADBEEF0BADF00D1234D2C38081AA7E
4 LW   3020 0 0 0 0 1 44556677 0 0 0 0
4 LW   1020 0 0 0 0 0 0 0 0 0 0
4 FILL 4020 0 FFEEDDCCBBAA99887766554433221100 1 0 0 0 1 0 3020 0123456789ABCDEF0011223344556677
4 LW   402C 0 0 0 0 1 FFEEDDCC 0 0 0 0
4 FILL 5020 0 55555555AAAAAAAA5A5A5A5AA5A5A5A5 1 1 0 0 1 0 4020 FFEEDDCCBBAA99887766554433221100
4 FILL 6020 0 0 0 0 0 0 1 1 5020 55555555AAAAAAAA5A5A5A5AA5A5A5A5
4 LW   6020 0 0 0 0 0 0 0 0 0 0
5 FILL A050 0 0F0E0D0C0B0A09080706050403020100 1 0 0 0 0 0 0 0
5 LW   A050 0 0 0 0 1 03020100 0 0 0 0
5 LW   B050 0 0 0 0 0 0 0 0 0 0
5 LBU  A05F 0 0 0 0 1 0000000F 0 0 0 0
5 LW   1A050 0 0 0 0 0 0 0 0 0 0
5 LB   A05E 0 0 0 0 1 0000000E 0 0 0 0

//--- project.f
rtl/dcache_pkg.sv
rtl/cache_ram.sv
rtl/dcache_d0.sv
rtl/dcache_d1.sv
rtl/dcache.sv
tb/dcache_props.sv
tb/dcache_tb.sv

//--- Makefile
# Verilator build and run for the data cache testbench.
# Override any variable on the command line, e.g. make run LOG=out.log

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG) || \
		(echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
